//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_split_cache_memory
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
hw/cache_pkg.sv
hw/cache_array.sv
hw/icache_ctrl.sv
hw/dcache_ctrl.sv
hw/backing_memory.sv
hw/split_cache_memory.sv
tests/tb_split_cache_memory.sv

//--- hw/backing_memory.sv
module backing_memory
	import cache_pkg::*;
(
	input  logic                   clk,
	input  logic [LINE_ADDR_W-1:0] i_i_line_addr,
	output line_t                  o_i_line,
	input  logic [LINE_ADDR_W-1:0] i_d_line_addr,
	output line_t                  o_d_line,
	input  logic                   i_d_we,
	input  line_t                  i_d_wline
);

	logic [WORD_W-1:0] mem [MEM_WORDS];

	// the image covers only the low words, the rest starts at zero
	initial begin
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a] = '0;
		end
		$readmemh(MEM_IMAGE, mem);
	end

	// instruction port, read only
	always_ff @(posedge clk) begin
		for (int w = 0; w < LINE_WORDS; w++) begin
			o_i_line[w] <= mem[{i_i_line_addr, OFFSET_W'(w)}];
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < LINE_WORDS; w++) begin
			o_d_line[w] <= mem[{i_d_line_addr, OFFSET_W'(w)}];
			if (i_d_we)
				mem[{i_d_line_addr, OFFSET_W'(w)}] <= i_d_wline[w];
		end
	end

endmodule

//--- hw/cache_array.sv
module cache_array
	import cache_pkg::*;
(
	input  logic               clk,
	input  logic               reset_n,
	input  logic [INDEX_W-1:0] i_index,
	input  logic [TAG_W-1:0]   i_tag,
	input  logic               i_we,
	input  line_t              i_wline,
	input  logic [TAG_W-1:0]   i_wtag,
	output logic               o_hit,
	output line_t              o_line,
	output logic [TAG_W-1:0]   o_tag
);

	logic [TAG_W-1:0] tags [LINES];
	line_t lines [LINES];
	logic [LINES-1:0] valid;

	assign o_tag = tags[i_index];
	assign o_line = lines[i_index];
	assign o_hit = valid[i_index] && (tags[i_index] == i_tag);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid <= '0;
		end else if (i_we) begin
			valid[i_index] <= 1'b1;
		end
	end

	// tag and line storage
	always_ff @(posedge clk) begin
		if (i_we) begin
			tags[i_index] <= i_wtag;
			lines[i_index] <= i_wline;
		end
	end

endmodule

//--- hw/cache_pkg.sv
package cache_pkg;

	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;

	// address split
	localparam int TAG_W = 11;
	localparam int INDEX_W = 3;
	localparam int OFFSET_W = 2;

	localparam int LINES = 8;
	localparam int LINE_WORDS = 4;

	// only the low address bits reach the store
	localparam int MEM_WORDS = 256;
	localparam int MEM_ADDR_W = 8;
	localparam int LINE_ADDR_W = MEM_ADDR_W - OFFSET_W;
	localparam int MEM_TAG_W = LINE_ADDR_W - INDEX_W;

	// cycles per line transfer, fill or write-back
	localparam int FILL_CYCLES = 5;
	localparam int FILL_CNT_W = $clog2(FILL_CYCLES);

	localparam string MEM_IMAGE = "hw/mem_image.hex";

	// one address, seen either as a plain word or as its cache fields
	typedef union packed {
		logic [ADDR_W-1:0] word;
		struct packed {
			logic [TAG_W-1:0]    tag;
			logic [INDEX_W-1:0]  index;
			logic [OFFSET_W-1:0] offset;
		} f;
	} cache_addr_t;

	// word 0 in the low bits
	typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

endpackage

//--- hw/dcache_ctrl.sv
module dcache_ctrl
	import cache_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   i_read,
	input  logic                   i_write,
	input  logic [ADDR_W-1:0]      i_addr,
	input  logic [WORD_W-1:0]      i_wdata,
	output logic [WORD_W-1:0]      o_data,
	output logic                   o_busy,
	output logic [INDEX_W-1:0]     o_arr_index,
	output logic [TAG_W-1:0]       o_arr_tag,
	output logic                   o_arr_we,
	output line_t                  o_arr_wline,
	output logic [TAG_W-1:0]       o_arr_wtag,
	input  logic                   i_arr_hit,
	input  line_t                  i_arr_line,
	input  logic [TAG_W-1:0]       i_arr_tag,
	output logic [LINE_ADDR_W-1:0] o_mem_line_addr,
	output logic                   o_mem_we,
	output line_t                  o_mem_wline,
	input  line_t                  i_mem_line
);

	cache_addr_t addr;
	logic miss;
	logic write_hit;
	logic wb_active;
	logic filling;
	logic xfer_last;
	logic [FILL_CNT_W-1:0] cnt;
	logic [LINES-1:0] dirty;
	logic [TAG_W-1:0] line_tag;
	logic [INDEX_W-1:0] line_index;
	line_t merged;

	assign addr.word = i_addr;
	assign miss = (i_read || i_write) && !i_arr_hit;
	assign o_busy = wb_active || filling || miss;
	assign write_hit = i_write && !o_busy;
	assign xfer_last = (wb_active || filling) && (cnt == FILL_CNT_W'(FILL_CYCLES - 1));

	always_comb begin
		merged = i_arr_line;
		merged[addr.f.offset] = i_wdata;
	end

	assign o_arr_index = (wb_active || filling) ? line_index : addr.f.index;
	assign o_arr_tag = addr.f.tag;
	assign o_arr_we = write_hit || (filling && xfer_last);
	assign o_arr_wline = filling ? i_mem_line : merged;
	assign o_arr_wtag = filling ? line_tag : addr.f.tag;

	// array is untouched during write-back, so the victim is read straight out of it
	assign o_mem_line_addr = wb_active ? {i_arr_tag[MEM_TAG_W-1:0], line_index}
		: {line_tag[MEM_TAG_W-1:0], line_index};
	assign o_mem_we = wb_active && xfer_last;
	assign o_mem_wline = i_arr_line;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wb_active <= 1'b0;
			filling <= 1'b0;
			cnt <= '0;
			dirty <= '0;
		end else begin
			if (wb_active) begin
				cnt <= cnt + 1'b1;
				if (xfer_last) begin
					wb_active <= 1'b0;
					filling <= 1'b1;
					cnt <= '0;
					dirty[line_index] <= 1'b0;
				end
			end else if (filling) begin
				cnt <= cnt + 1'b1;
				if (xfer_last)
					filling <= 1'b0;
			end else if (miss) begin
				cnt <= '0;
				// a dirty line is always valid, only a write hit sets it
				if (dirty[addr.f.index])
					wb_active <= 1'b1;
				else
					filling <= 1'b1;
			end
			if (write_hit)
				dirty[addr.f.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!wb_active && !filling && miss) begin
			line_tag <= addr.f.tag;
			line_index <= addr.f.index;
		end
		if (i_read && !o_busy)
			o_data <= i_arr_line[addr.f.offset];
	end

endmodule

//--- hw/icache_ctrl.sv
module icache_ctrl
	import cache_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   i_read,
	input  logic [ADDR_W-1:0]      i_addr,
	output logic [WORD_W-1:0]      o_data,
	output logic                   o_busy,
	output logic [INDEX_W-1:0]     o_arr_index,
	output logic [TAG_W-1:0]       o_arr_tag,
	output logic                   o_arr_we,
	output line_t                  o_arr_wline,
	output logic [TAG_W-1:0]       o_arr_wtag,
	input  logic                   i_arr_hit,
	input  line_t                  i_arr_line,
	output logic [LINE_ADDR_W-1:0] o_mem_line_addr,
	input  line_t                  i_mem_line
);

	cache_addr_t addr;
	logic miss;
	logic filling;
	logic fill_last;
	logic [FILL_CNT_W-1:0] cnt;
	logic [TAG_W-1:0] fill_tag;
	logic [INDEX_W-1:0] fill_index;

	assign addr.word = i_addr;
	assign miss = i_read && !i_arr_hit;
	assign fill_last = filling && (cnt == FILL_CNT_W'(FILL_CYCLES - 1));
	assign o_busy = filling || miss;

	assign o_arr_index = filling ? fill_index : addr.f.index;
	assign o_arr_tag = addr.f.tag;
	assign o_arr_we = fill_last;
	assign o_arr_wline = i_mem_line;
	assign o_arr_wtag = fill_tag;

	// store sees the line being filled, read data lands one cycle later
	assign o_mem_line_addr = {fill_tag[MEM_TAG_W-1:0], fill_index};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			filling <= 1'b0;
			cnt <= '0;
		end else if (filling) begin
			cnt <= cnt + 1'b1;
			if (fill_last)
				filling <= 1'b0;
		end else if (miss) begin
			filling <= 1'b1;
			cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!filling && miss) begin
			fill_tag <= addr.f.tag;
			fill_index <= addr.f.index;
		end
		// completed read
		if (i_read && !o_busy)
			o_data <= i_arr_line[addr.f.offset];
	end

endmodule

//--- hw/mem_image.hex
// one 16-bit word per line, store addresses 0x00 to 0x1f in order
5a00
5b01
5802
5903
5e04
5f05
5c06
5d07
5208
5309
500a
510b
560c
570d
540e
550f
4a10
4b11
4812
4913
4e14
4f15
4c16
4d17
4218
4319
401a
411b
461c
471d
441e
451f

//--- hw/split_cache_memory.sv
module split_cache_memory
	import cache_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,
	input  logic              i_i_read,
	input  logic [ADDR_W-1:0] i_i_addr,
	output logic [WORD_W-1:0] o_i_data,
	output logic              o_i_busy,
	input  logic              i_d_read,
	input  logic              i_d_write,
	input  logic [ADDR_W-1:0] i_d_addr,
	input  logic [WORD_W-1:0] i_d_wdata,
	output logic [WORD_W-1:0] o_d_rdata,
	output logic              o_d_busy
);

	logic [INDEX_W-1:0] i_index, d_index;
	logic [TAG_W-1:0] i_tag, d_tag;
	logic i_we, d_we;
	line_t i_wline, d_wline;
	logic [TAG_W-1:0] i_wtag, d_wtag;
	logic i_hit, d_hit;
	line_t i_line, d_line;
	logic [TAG_W-1:0] d_stored_tag;
	logic [LINE_ADDR_W-1:0] i_mem_addr, d_mem_addr;
	line_t i_mem_line, d_mem_line;
	logic d_mem_we;
	line_t d_mem_wline;

	icache_ctrl u_icache_ctrl (
		.clk(clk), .reset_n(reset_n),
		.i_read(i_i_read), .i_addr(i_i_addr), .o_data(o_i_data), .o_busy(o_i_busy),
		.o_arr_index(i_index), .o_arr_tag(i_tag), .o_arr_we(i_we),
		.o_arr_wline(i_wline), .o_arr_wtag(i_wtag),
		.i_arr_hit(i_hit), .i_arr_line(i_line),
		.o_mem_line_addr(i_mem_addr), .i_mem_line(i_mem_line)
	);

	dcache_ctrl u_dcache_ctrl (
		.clk(clk), .reset_n(reset_n),
		.i_read(i_d_read), .i_write(i_d_write), .i_addr(i_d_addr), .i_wdata(i_d_wdata),
		.o_data(o_d_rdata), .o_busy(o_d_busy),
		.o_arr_index(d_index), .o_arr_tag(d_tag), .o_arr_we(d_we),
		.o_arr_wline(d_wline), .o_arr_wtag(d_wtag),
		.i_arr_hit(d_hit), .i_arr_line(d_line), .i_arr_tag(d_stored_tag),
		.o_mem_line_addr(d_mem_addr), .o_mem_we(d_mem_we), .o_mem_wline(d_mem_wline),
		.i_mem_line(d_mem_line)
	);

	// stored tag is not needed on the read-only side
	cache_array u_icache_array (
		.clk(clk), .reset_n(reset_n), .i_index(i_index), .i_tag(i_tag),
		.i_we(i_we), .i_wline(i_wline), .i_wtag(i_wtag),
		.o_hit(i_hit), .o_line(i_line), .o_tag()
	);

	cache_array u_dcache_array (
		.clk(clk), .reset_n(reset_n), .i_index(d_index), .i_tag(d_tag),
		.i_we(d_we), .i_wline(d_wline), .i_wtag(d_wtag),
		.o_hit(d_hit), .o_line(d_line), .o_tag(d_stored_tag)
	);

	backing_memory u_backing_memory (
		.clk(clk),
		.i_i_line_addr(i_mem_addr), .o_i_line(i_mem_line),
		.i_d_line_addr(d_mem_addr), .o_d_line(d_mem_line),
		.i_d_we(d_mem_we), .i_d_wline(d_mem_wline)
	);

endmodule

//--- tests/tb_split_cache_memory.sv
module tb_split_cache_memory
	import cache_pkg::*;
();

	localparam int HALF_PERIOD = 20;
	localparam int SETTLE = 10;
	localparam int RESET_CYCLES = 10;
	localparam int IMAGE_WORDS = 32;
	localparam int RAND_ACCESSES = 16;
	// about 80 accesses at no more than 2*FILL_CYCLES+3 cycles each, with wide margin
	localparam int MAX_CYCLES = 3000;

	logic clk;
	logic reset_n;
	logic i_i_read;
	logic [ADDR_W-1:0] i_i_addr;
	logic [WORD_W-1:0] o_i_data;
	logic o_i_busy;
	logic i_d_read;
	logic i_d_write;
	logic [ADDR_W-1:0] i_d_addr;
	logic [WORD_W-1:0] i_d_wdata;
	logic [WORD_W-1:0] o_d_rdata;
	logic o_d_busy;

	// image as loaded, store contents as far as known, and the data side view
	logic [WORD_W-1:0] image [MEM_WORDS];
	logic [WORD_W-1:0] store_model [MEM_WORDS];
	logic [WORD_W-1:0] model [MEM_WORDS];
	int cycles = 0;
	integer seed;

	split_cache_memory split_cache_memory_inst (
		.clk(clk), .reset_n(reset_n),
		.i_i_read(i_i_read), .i_i_addr(i_i_addr), .o_i_data(o_i_data), .o_i_busy(o_i_busy),
		.i_d_read(i_d_read), .i_d_write(i_d_write), .i_d_addr(i_d_addr),
		.i_d_wdata(i_d_wdata), .o_d_rdata(o_d_rdata), .o_d_busy(o_d_busy)
	);

	initial clk = 1'b0;
	always #HALF_PERIOD clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT never finished an access", cycles);
			$display("STATUS: FAIL");
			$fatal(1, "simulation stopped on timeout");
		end
	end

	task automatic stop_with_error(input string msg);
		$display("Error at time %0t: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// request on the falling edge, busy sampled mid low phase where it is settled
	task automatic fetch_word(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] data,
		output bit missed);
		missed = 1'b0;
		@(negedge clk);
		i_i_read = 1'b1;
		i_i_addr = addr;
		#SETTLE;
		while (o_i_busy) begin
			missed = 1'b1;
			@(negedge clk);
			#SETTLE;
		end
		@(posedge clk);
		@(negedge clk);
		data = o_i_data;
		i_i_read = 1'b0;
	endtask

	task automatic access_data(input bit wr, input logic [ADDR_W-1:0] addr,
		input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] data, output bit missed);
		missed = 1'b0;
		@(negedge clk);
		i_d_read = !wr;
		i_d_write = wr;
		i_d_addr = addr;
		i_d_wdata = wdata;
		#SETTLE;
		while (o_d_busy) begin
			missed = 1'b1;
			@(negedge clk);
			#SETTLE;
		end
		@(posedge clk);
		@(negedge clk);
		data = o_d_rdata;
		i_d_read = 1'b0;
		i_d_write = 1'b0;
	endtask

	task automatic check_reset_misses();
		logic [WORD_W-1:0] data;
		bit missed;
		fetch_word(16'h0000, data, missed);
		assert (missed)
			else stop_with_error("first fetch after reset did not raise o_i_busy");
		assert (data === image[0])
			else stop_with_error($sformatf("fetch 0000 gave %h, expected %h", data, image[0]));
		access_data(1'b0, 16'h0004, '0, data, missed);
		assert (missed)
			else stop_with_error("first data read after reset did not raise o_d_busy");
		assert (data === model[4])
			else stop_with_error($sformatf("read 0004 gave %h, expected %h", data, model[4]));
	endtask

	task automatic sweep_image_fetches();
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
		bit missed;
		for (int a = 0; a < IMAGE_WORDS; a++) begin
			addr = ADDR_W'(a);
			fetch_word(addr, data, missed);
			assert (data === store_model[addr[MEM_ADDR_W-1:0]])
				else stop_with_error($sformatf("fetch %h gave %h, expected %h", addr, data,
					store_model[addr[MEM_ADDR_W-1:0]]));
			if (addr[OFFSET_W-1:0] != '0)
				assert (!missed)
					else stop_with_error($sformatf("fetch %h missed in a filled line", addr));
		end
	endtask

	task automatic random_write_read();
		logic [ADDR_W-1:0] addrs [RAND_ACCESSES];
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
		logic [WORD_W-1:0] data;
		bit missed;
		// low byte stays in 40..7f, upper tag bits random
		for (int n = 0; n < RAND_ACCESSES; n++) begin
			addr = (ADDR_W'($random(seed)) & 16'hff3f) | 16'h0040;
			wdata = WORD_W'($random(seed));
			addrs[n] = addr;
			access_data(1'b1, addr, wdata, data, missed);
			model[addr[MEM_ADDR_W-1:0]] = wdata;
		end
		for (int n = 0; n < RAND_ACCESSES; n++) begin
			access_data(1'b0, addrs[n], '0, data, missed);
			assert (data === model[addrs[n][MEM_ADDR_W-1:0]])
				else stop_with_error($sformatf("read %h gave %h, expected %h", addrs[n], data,
					model[addrs[n][MEM_ADDR_W-1:0]]));
		end
	endtask

	task automatic eviction_refill();
		logic [ADDR_W-1:0] addr;
		logic [ADDR_W-1:0] conflict;
		logic [WORD_W-1:0] wdata;
		logic [WORD_W-1:0] data;
		bit missed;
		addr = 16'h0080 | (ADDR_W'($random(seed)) & 16'h001f);
		conflict = addr + 16'd32;
		wdata = WORD_W'($random(seed));
		access_data(1'b1, addr, wdata, data, missed);
		model[addr[MEM_ADDR_W-1:0]] = wdata;
		access_data(1'b0, conflict, '0, data, missed);
		assert (missed)
			else stop_with_error($sformatf("read %h hit a line of another tag", conflict));
		assert (data === model[conflict[MEM_ADDR_W-1:0]])
			else stop_with_error($sformatf("read %h gave %h", conflict, data));
		access_data(1'b0, addr, '0, data, missed);
		assert (missed) else stop_with_error($sformatf("read %h hit after eviction", addr));
		assert (data === wdata)
			else stop_with_error($sformatf("read %h gave %h, expected %h", addr, data, wdata));
	endtask

	task automatic split_visibility();
		logic [ADDR_W-1:0] addr;
		logic [ADDR_W-1:0] conflict;
		logic [MEM_ADDR_W-1:0] base;
		logic [WORD_W-1:0] wdata;
		logic [WORD_W-1:0] data;
		bit missed;
		addr = 16'h0015;
		conflict = 16'h0035;
		base = {addr[MEM_ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
		wdata = ~image[addr[MEM_ADDR_W-1:0]];
		access_data(1'b1, addr, wdata, data, missed);
		model[addr[MEM_ADDR_W-1:0]] = wdata;
		// push the line out of the instruction side so the next fetch reads the store
		fetch_word(conflict, data, missed);
		assert (data === store_model[conflict[MEM_ADDR_W-1:0]])
			else stop_with_error($sformatf("fetch %h gave %h", conflict, data));
		fetch_word(addr, data, missed);
		assert (missed) else stop_with_error($sformatf("fetch %h hit a replaced line", addr));
		assert (data === store_model[addr[MEM_ADDR_W-1:0]])
			else stop_with_error($sformatf("fetch %h saw %h before write-back", addr, data));
		// reading the other tag forces the dirty line out to the store
		access_data(1'b0, conflict, '0, data, missed);
		assert (data === model[conflict[MEM_ADDR_W-1:0]])
			else stop_with_error($sformatf("read %h gave %h", conflict, data));
		for (int w = 0; w < LINE_WORDS; w++) begin
			store_model[base + MEM_ADDR_W'(w)] = model[base + MEM_ADDR_W'(w)];
		end
		fetch_word(conflict, data, missed);
		assert (data === store_model[conflict[MEM_ADDR_W-1:0]])
			else stop_with_error($sformatf("fetch %h gave %h", conflict, data));
		fetch_word(addr, data, missed);
		assert (missed) else stop_with_error($sformatf("fetch %h hit a replaced line", addr));
		assert (data === wdata)
			else stop_with_error($sformatf("fetch %h gave %h, expected %h", addr, data, wdata));
	endtask

	initial begin
		seed = 32'h8ea;
		reset_n = 1'b0;
		i_i_read = 1'b0;
		i_i_addr = '0;
		i_d_read = 1'b0;
		i_d_write = 1'b0;
		i_d_addr = '0;
		i_d_wdata = '0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			image[a] = '0;
		end
		$readmemh(MEM_IMAGE, image, 0, IMAGE_WORDS - 1);
		for (int a = 0; a < MEM_WORDS; a++) begin
			store_model[a] = image[a];
			model[a] = image[a];
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		check_reset_misses();
		sweep_image_fetches();
		random_write_read();
		eviction_refill();
		split_visibility();

		$display("STATUS: PASS");
		$finish;
	end

endmodule
